//--- Makefile
VERILATOR  ?= verilator
TOP        := cpuCoreTb
RTL_TOP    := cpuCore
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/cpuCoreTb.sv
`default_nettype none

module cpuCoreTb;

	timeunit 1ns;
	timeprecision 100ps;

	logic            clk;
	logic            rst;
	cpuPkg::word_t   instr;
	logic            instrValid;
	logic            stall;
	logic            wbValid;
	cpuPkg::regIdx_t wbReg;
	cpuPkg::word_t   wbData;
	logic            halted;

	int            seed;
	int            errorCount;
	int            checkCount;
	int            issuedCount;
	int            lastStallCycles;
	string         testName;
	logic          haltIssued;
	logic [19:0]   expectedWb;
	logic [19:0]   expectQ [$];
	cpuPkg::word_t refRegs [16];
	cpuPkg::word_t refMem [256];

	cpuCore #(.DataAddrWidth(8)) dut (.clk, .rst, .instr, .instrValid, .stall, .wbValid,
		.wbReg, .wbData, .halted);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic cpuPkg::word_t encodeRegs(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic cpuPkg::word_t encodeImm(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [7:0] randomByte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic checkEqual(input string item, input cpuPkg::word_t expected,
		input cpuPkg::word_t actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: %s expected %h, actual %h", testName, item, expected, actual);
		end
	endtask

	// Sequential model of one instruction, then present it until accepted
	task automatic issue(input cpuPkg::word_t ins);
		logic [3:0]    op;
		logic [3:0]    rd;
		logic [3:0]    rs;
		logic [3:0]    rt;
		logic [7:0]    addr;
		cpuPkg::word_t result;
		logic          writes;
		int            stallCycles;
		op = ins[15:12];
		rd = ins[11:8];
		rs = ins[7:4];
		rt = ins[3:0];
		addr = refRegs[rs][7:0] + {4'h0, rt};
		result = '0;
		writes = 1'b1;
		if (!haltIssued) begin
			case (op)
				cpuPkg::OpAdd: result = refRegs[rs] + refRegs[rt];
				cpuPkg::OpSub: result = refRegs[rs] - refRegs[rt];
				cpuPkg::OpXor: result = refRegs[rs] ^ refRegs[rt];
				cpuPkg::OpAnd: result = refRegs[rs] & refRegs[rt];
				cpuPkg::OpSll: result = refRegs[rs] << rt;
				cpuPkg::OpSrl: result = refRegs[rs] >> rt;
				cpuPkg::OpLw:  result = refMem[addr];
				cpuPkg::OpLlb: result = {{8{ins[7]}}, ins[7:0]};
				cpuPkg::OpLhb: result = {ins[7:0], refRegs[rd][7:0]};
				cpuPkg::OpSw: begin
					refMem[addr] = refRegs[rd];
					writes = 1'b0;
				end
				cpuPkg::OpHlt: begin
					haltIssued = 1'b1;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && (rd != 4'd0)) begin
				refRegs[rd] = result;
				expectQ.push_back({rd, result});
			end
		end
		issuedCount++;
		instr = ins;
		instrValid = 1'b1;
		stallCycles = 0;
		@(negedge clk);
		while (stall) begin
			stallCycles++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		lastStallCycles = stallCycles;
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while ((expectQ.size() != 0) && (cycles < 50)) begin
			@(posedge clk);
			cycles++;
		end
		if (expectQ.size() != 0) begin
			errorCount++;
			$display("Test %s: %0d expected writebacks never arrived", testName, expectQ.size());
		end
		repeat (3) @(posedge clk);
		#1;
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && wbValid) begin
			if (expectQ.size() == 0) begin
				errorCount++;
				$display("Test %s: unexpected writeback of %h to register %0d", testName,
					wbData, wbReg);
			end else begin
				expectedWb = expectQ.pop_front();
				checkEqual("writeback register", {12'h000, expectedWb[19:16]}, {12'h000, wbReg});
				checkEqual("writeback data", expectedWb[15:0], wbData);
			end
		end
	end

	task automatic aluOperations();
		testName = "aluOperations";
		issue(encodeImm(cpuPkg::OpLlb, 4'd1, randomByte()));
		issue(encodeImm(cpuPkg::OpLlb, 4'd2, randomByte()));
		issue(encodeImm(cpuPkg::OpLlb, 4'd3, randomByte()));
		issue(encodeImm(cpuPkg::OpLlb, 4'd4, randomByte()));
		issue(encodeImm(cpuPkg::OpLhb, 4'd1, randomByte()));
		issue(encodeImm(cpuPkg::OpLhb, 4'd2, randomByte()));
		drain();
		issue(encodeRegs(cpuPkg::OpAdd, 4'd5, 4'd1, 4'd2));
		issue(encodeRegs(cpuPkg::OpSub, 4'd6, 4'd1, 4'd2));
		issue(encodeRegs(cpuPkg::OpXor, 4'd7, 4'd3, 4'd4));
		issue(encodeRegs(cpuPkg::OpAnd, 4'd8, 4'd3, 4'd4));
		issue(encodeRegs(cpuPkg::OpSll, 4'd9, 4'd1, 4'd3));
		issue(encodeRegs(cpuPkg::OpSrl, 4'd10, 4'd2, 4'd5));
		issue(encodeRegs(cpuPkg::OpSrl, 4'd11, 4'd3, 4'd15));
		drain();
	endtask

	task automatic forwardingChains();
		testName = "forwardingChains";
		issue(encodeImm(cpuPkg::OpLlb, 4'd1, randomByte()));
		// r2 from EX/MEM, then r1 from MEM/WB
		issue(encodeRegs(cpuPkg::OpAdd, 4'd2, 4'd1, 4'd1));
		issue(encodeRegs(cpuPkg::OpAdd, 4'd3, 4'd2, 4'd1));
		issue(encodeRegs(cpuPkg::OpSub, 4'd4, 4'd3, 4'd2));
		issue(encodeRegs(cpuPkg::OpXor, 4'd5, 4'd4, 4'd3));
		issue(encodeImm(cpuPkg::OpLhb, 4'd5, randomByte()));
		issue(encodeRegs(cpuPkg::OpAnd, 4'd6, 4'd5, 4'd4));
		issue(encodeRegs(cpuPkg::OpSll, 4'd7, 4'd6, 4'd1));
		drain();
	endtask

	task automatic loadUseStall();
		testName = "loadUseStall";
		issue(encodeImm(cpuPkg::OpLlb, 4'd1, 8'h10));
		issue(encodeImm(cpuPkg::OpLlb, 4'd2, randomByte()));
		issue(encodeImm(cpuPkg::OpLhb, 4'd2, randomByte()));
		issue(encodeRegs(cpuPkg::OpSw, 4'd2, 4'd1, 4'd2));
		issue(encodeRegs(cpuPkg::OpLw, 4'd3, 4'd1, 4'd2));
		issue(encodeRegs(cpuPkg::OpAdd, 4'd4, 4'd3, 4'd3));
		checkEqual("stall cycles on rs", 16'd1, 16'(lastStallCycles));
		issue(encodeRegs(cpuPkg::OpLw, 4'd5, 4'd1, 4'd2));
		issue(encodeRegs(cpuPkg::OpSub, 4'd6, 4'd1, 4'd5));
		checkEqual("stall cycles on rt", 16'd1, 16'(lastStallCycles));
		issue(encodeRegs(cpuPkg::OpLw, 4'd7, 4'd1, 4'd2));
		issue(encodeRegs(cpuPkg::OpXor, 4'd8, 4'd1, 4'd1));
		checkEqual("stall cycles, independent", 16'd0, 16'(lastStallCycles));
		issue(encodeRegs(cpuPkg::OpSw, 4'd7, 4'd1, 4'd3));
		issue(encodeRegs(cpuPkg::OpLw, 4'd9, 4'd1, 4'd3));
		// Store data read through rd
		issue(encodeRegs(cpuPkg::OpLw, 4'd10, 4'd1, 4'd3));
		issue(encodeRegs(cpuPkg::OpSw, 4'd10, 4'd1, 4'd4));
		checkEqual("stall cycles on store data", 16'd1, 16'(lastStallCycles));
		issue(encodeRegs(cpuPkg::OpLw, 4'd11, 4'd1, 4'd4));
		drain();
	endtask

	task automatic storeLoadAndZero();
		testName = "storeLoadAndZero";
		issue(encodeImm(cpuPkg::OpLlb, 4'd1, 8'h40));
		issue(encodeImm(cpuPkg::OpLlb, 4'd2, randomByte()));
		issue(encodeRegs(cpuPkg::OpSw, 4'd2, 4'd1, 4'd5));
		issue(encodeRegs(cpuPkg::OpLw, 4'd3, 4'd1, 4'd5));
		issue(encodeImm(cpuPkg::OpLlb, 4'd0, 8'h7f));
		issue(encodeRegs(cpuPkg::OpAdd, 4'd4, 4'd0, 4'd2));
		issue(encodeRegs(cpuPkg::OpAdd, 4'd0, 4'd2, 4'd2));
		issue(encodeRegs(cpuPkg::OpXor, 4'd5, 4'd0, 4'd0));
		issue(encodeRegs(cpuPkg::OpLw, 4'd0, 4'd1, 4'd5));
		issue(encodeRegs(cpuPkg::OpSw, 4'd0, 4'd1, 4'd6));
		issue(encodeRegs(cpuPkg::OpLw, 4'd6, 4'd1, 4'd6));
		drain();
	endtask

	task automatic idleAndHalt();
		int waitCycles;
		testName = "idleAndHalt";
		instrValid = 1'b0;
		repeat (10) begin
			instr = {randomByte(), randomByte()};
			@(posedge clk);
			#1;
		end
		issue(encodeRegs(cpuPkg::OpAdd, 4'd11, 4'd1, 4'd2));
		issue(encodeRegs(cpuPkg::OpHlt, 4'd0, 4'd0, 4'd0));
		// Accepted before halted shows, then squashed
		issue(encodeRegs(cpuPkg::OpAdd, 4'd12, 4'd1, 4'd1));
		issue(encodeImm(cpuPkg::OpLlb, 4'd13, 8'h5a));
		instr = encodeRegs(cpuPkg::OpXor, 4'd14, 4'd1, 4'd2);
		instrValid = 1'b1;
		waitCycles = 0;
		while ((halted !== 1'b1) && (waitCycles < 20)) begin
			@(posedge clk);
			#1;
			waitCycles++;
		end
		checkEqual("halted", 16'd1, {15'h0000, halted});
		repeat (10) begin
			@(negedge clk);
			checkEqual("halted held", 16'd1, {15'h0000, halted});
			checkEqual("stall held", 16'd1, {15'h0000, stall});
		end
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		drain();
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 20 * issuedCount + 200) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycles);
		$display("tests failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		seed = 32'hc047_7007;
		errorCount = 0;
		checkCount = 0;
		issuedCount = 0;
		lastStallCycles = 0;
		haltIssued = 1'b0;
		testName = "reset";
		for (int i = 0; i < 16; i++) begin
			refRegs[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		aluOperations();
		forwardingChains();
		loadUseStall();
		storeLoadAndZero();
		idleAndHalt();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cpuCore.sv
`default_nettype none

module cpuCore #(
	parameter int DataAddrWidth = 8
) (
	input  logic            clk,
	input  logic            rst,
	input  cpuPkg::word_t   instr,
	input  logic            instrValid,
	output logic            stall,
	output logic            wbValid,
	output cpuPkg::regIdx_t wbReg,
	output cpuPkg::word_t   wbData,
	output logic            halted
);

	cpuPkg::regIdx_t  src1, src2, dst;
	cpuPkg::imm8_t    imm;
	cpuPkg::exCtrl_t  exCtrl;
	cpuPkg::memCtrl_t memCtrl;
	cpuPkg::wbCtrl_t  wbCtrl;
	logic             readsSrc2;
	cpuPkg::word_t    data1, data2;
	logic             loadUseStall;
	logic             bubble;
	cpuPkg::idEx_t    idEx;
	cpuPkg::word_t    aluResult, storeData;
	cpuPkg::word_t    exMemResult, memWbData;
	cpuPkg::wbCtrl_t  exMemWb, exMemFwd, memWbWb;
	cpuPkg::regIdx_t  exMemDst, memWbDst;
	logic             exMemRead;
	logic             haltedReg;

	instrDecode decode (.instr, .src1, .src2, .dst, .imm, .exCtrl, .memCtrl, .wbCtrl,
		.readsSrc2);

	regFile rf (.clk, .rst, .rdAddr1(src1), .rdAddr2(src2), .rdData1(data1),
		.rdData2(data2), .wrEn(wbValid), .wrAddr(memWbDst), .wrData(memWbData));

	hazardUnit hazard (.clk, .rst, .src1, .src2, .readsSrc2,
		.instrValid(instrValid && !halted), .exMemRead(idEx.mem.memRead),
		.exDst(idEx.dst), .stall(loadUseStall));

	assign stall  = loadUseStall || halted;
	assign bubble = stall || !instrValid || halted;

	pipelineIdEx idExReg (.clk, .rst, .bubble, .exCtrl, .memCtrl, .wbCtrl, .data1, .data2,
		.src1, .src2, .dst, .imm, .idEx);

	// Loads in EX/MEM have no data yet, so they are not forwarded
	always_comb begin
		exMemFwd = exMemWb;
		exMemFwd.regWrite = exMemWb.regWrite && !exMemRead;
	end

	execStage exec (.idEx, .exMemResult, .exMemWb(exMemFwd), .exMemDst, .memWbData,
		.memWbWb, .memWbDst, .aluResult, .storeData);

	memWbStage #(.DataAddrWidth(DataAddrWidth)) memWb (.clk, .rst, .aluResult, .storeData,
		.idEx, .exMemResult, .exMemWb, .exMemDst, .exMemRead, .memWbData, .memWbWb,
		.memWbDst);

	// Sticky halt, visible as soon as HLT reaches writeback
	always_ff @(posedge clk) begin
		if (rst) begin
			haltedReg <= 1'b0;
		end else if (memWbWb.halt) begin
			haltedReg <= 1'b1;
		end
	end

	assign halted = haltedReg || memWbWb.halt;

	// Anything younger than HLT is squashed at writeback
	assign wbValid = memWbWb.regWrite && (memWbDst != '0) && !haltedReg;
	assign wbReg   = memWbDst;
	assign wbData  = memWbData;

endmodule

`default_nettype wire

//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0]  regIdx_t;
	typedef logic [7:0]  imm8_t;

	typedef enum logic [2:0] {
		AluAdd  = 3'd0,
		AluSub  = 3'd1,
		AluXor  = 3'd2,
		AluAnd  = 3'd3,
		AluSll  = 3'd4,
		AluSrl  = 3'd5,
		AluPassB = 3'd6
	} aluOp_t;

	// Opcode field, bits 15 to 12
	localparam logic [3:0] OpAdd = 4'h0;
	localparam logic [3:0] OpSub = 4'h1;
	localparam logic [3:0] OpXor = 4'h2;
	localparam logic [3:0] OpAnd = 4'h3;
	localparam logic [3:0] OpSll = 4'h4;
	localparam logic [3:0] OpSrl = 4'h5;
	localparam logic [3:0] OpLw  = 4'h8;
	localparam logic [3:0] OpSw  = 4'h9;
	localparam logic [3:0] OpLlb = 4'ha;
	localparam logic [3:0] OpLhb = 4'hb;
	localparam logic [3:0] OpHlt = 4'hf;

	typedef struct packed {
		aluOp_t aluOp;
		logic   aluSrc;
		logic   lbIns;
		logic   lhb;
	} exCtrl_t;

	typedef struct packed {
		logic memRead;
		logic memWrite;
	} memCtrl_t;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic halt;
	} wbCtrl_t;

	// All zeros is a bubble
	typedef struct packed {
		exCtrl_t  ex;
		memCtrl_t mem;
		wbCtrl_t  wb;
		word_t    data1;
		word_t    data2;
		regIdx_t  src1;
		regIdx_t  src2;
		regIdx_t  dst;
		imm8_t    imm;
	} idEx_t;

endpackage

`default_nettype wire

//--- verilog/execStage.sv
`default_nettype none

module execStage (
	input  cpuPkg::idEx_t   idEx,
	input  cpuPkg::word_t   exMemResult,
	input  cpuPkg::wbCtrl_t exMemWb,
	input  cpuPkg::regIdx_t exMemDst,
	input  cpuPkg::word_t   memWbData,
	input  cpuPkg::wbCtrl_t memWbWb,
	input  cpuPkg::regIdx_t memWbDst,
	output cpuPkg::word_t   aluResult,
	output cpuPkg::word_t   storeData
);

	cpuPkg::word_t regA;
	cpuPkg::word_t regB;
	cpuPkg::word_t immWord;
	cpuPkg::word_t operandB;
	cpuPkg::word_t aluOut;
	logic [3:0]    shamt;

	// Nearest producer wins
	function automatic cpuPkg::word_t forwardOperand(
		input cpuPkg::regIdx_t src,
		input cpuPkg::word_t   regVal
	);
		if (exMemWb.regWrite && (exMemDst != '0) && (exMemDst == src)) begin
			return exMemResult;
		end else if (memWbWb.regWrite && (memWbDst != '0) && (memWbDst == src)) begin
			return memWbData;
		end
		return regVal;
	endfunction

	always_comb begin
		regA = forwardOperand(idEx.src1, idEx.data1);
		regB = forwardOperand(idEx.src2, idEx.data2);
	end

	// SW reads rd through the second source
	assign storeData = regB;

	// 8-bit signed field for byte loads, 4-bit offset or shift otherwise
	assign immWord = idEx.ex.lbIns ? {{8{idEx.imm[7]}}, idEx.imm} : {12'h000, idEx.imm[3:0]};
	assign operandB = idEx.ex.aluSrc ? immWord : regB;
	assign shamt = operandB[3:0];

	always_comb begin
		case (idEx.ex.aluOp)
			cpuPkg::AluAdd:   aluOut = regA + operandB;
			cpuPkg::AluSub:   aluOut = regA - operandB;
			cpuPkg::AluXor:   aluOut = regA ^ operandB;
			cpuPkg::AluAnd:   aluOut = regA & operandB;
			cpuPkg::AluSll:   aluOut = regA << shamt;
			cpuPkg::AluSrl:   aluOut = regA >> shamt;
			cpuPkg::AluPassB: aluOut = operandB;
			default:          aluOut = '0;
		endcase
	end

	// LHB merges the new high byte with rd's current low byte
	assign aluResult = idEx.ex.lhb ? {idEx.imm, regB[7:0]} : aluOut;

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none

module hazardUnit (
	input  logic            clk,
	input  logic            rst,
	input  cpuPkg::regIdx_t src1,
	input  cpuPkg::regIdx_t src2,
	input  logic            readsSrc2,
	input  logic            instrValid,
	input  logic            exMemRead,
	input  cpuPkg::regIdx_t exDst,
	output logic            stall
);

	logic hit1;
	logic hit2;

	// Load in ID/EX whose data is not ready for the next EX
	assign hit1 = (src1 == exDst);
	assign hit2 = readsSrc2 && (src2 == exDst);

	assign stall = instrValid && exMemRead && (exDst != '0) && (hit1 || hit2);

	// The stalled cycle puts a bubble into ID/EX, so the load has moved on
	singleCycleStall: assert property (@(posedge clk) disable iff (rst)
		stall |=> !stall);

endmodule

`default_nettype wire

//--- verilog/instrDecode.sv
`default_nettype none

module instrDecode (
	input  cpuPkg::word_t    instr,
	output cpuPkg::regIdx_t  src1,
	output cpuPkg::regIdx_t  src2,
	output cpuPkg::regIdx_t  dst,
	output cpuPkg::imm8_t    imm,
	output cpuPkg::exCtrl_t  exCtrl,
	output cpuPkg::memCtrl_t memCtrl,
	output cpuPkg::wbCtrl_t  wbCtrl,
	output logic             readsSrc2
);

	logic [3:0] opcode;
	logic       rdAsSrc2;
	logic       noSrc1;

	assign opcode = instr[15:12];
	assign dst    = instr[11:8];
	assign imm    = instr[7:0];

	// SW stores rd, LHB keeps the low byte of rd
	assign rdAsSrc2 = (opcode == cpuPkg::OpSw) || (opcode == cpuPkg::OpLhb);
	// Byte loads carry immediate bits where rs would be
	assign noSrc1 = (opcode == cpuPkg::OpLlb) || (opcode == cpuPkg::OpLhb) ||
		(opcode == cpuPkg::OpHlt);

	assign src1 = noSrc1 ? '0 : instr[7:4];
	assign src2 = rdAsSrc2 ? instr[11:8] : instr[3:0];

	always_comb begin
		exCtrl    = '0;
		memCtrl   = '0;
		wbCtrl    = '0;
		readsSrc2 = 1'b0;
		case (opcode)
			cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpXor, cpuPkg::OpAnd: begin
				wbCtrl.regWrite = 1'b1;
				readsSrc2 = 1'b1;
				case (opcode)
					cpuPkg::OpSub: exCtrl.aluOp = cpuPkg::AluSub;
					cpuPkg::OpXor: exCtrl.aluOp = cpuPkg::AluXor;
					cpuPkg::OpAnd: exCtrl.aluOp = cpuPkg::AluAnd;
					default:       exCtrl.aluOp = cpuPkg::AluAdd;
				endcase
			end
			cpuPkg::OpSll, cpuPkg::OpSrl: begin
				exCtrl.aluOp = (opcode == cpuPkg::OpSll) ? cpuPkg::AluSll : cpuPkg::AluSrl;
				exCtrl.aluSrc = 1'b1;
				wbCtrl.regWrite = 1'b1;
			end
			cpuPkg::OpLw: begin
				exCtrl.aluOp = cpuPkg::AluAdd;
				exCtrl.aluSrc = 1'b1;
				memCtrl.memRead = 1'b1;
				wbCtrl.regWrite = 1'b1;
				wbCtrl.memToReg = 1'b1;
			end
			cpuPkg::OpSw: begin
				exCtrl.aluOp = cpuPkg::AluAdd;
				exCtrl.aluSrc = 1'b1;
				memCtrl.memWrite = 1'b1;
				readsSrc2 = 1'b1;
			end
			cpuPkg::OpLlb, cpuPkg::OpLhb: begin
				exCtrl.aluOp = cpuPkg::AluPassB;
				exCtrl.aluSrc = 1'b1;
				exCtrl.lbIns = 1'b1;
				exCtrl.lhb = (opcode == cpuPkg::OpLhb);
				wbCtrl.regWrite = 1'b1;
				readsSrc2 = (opcode == cpuPkg::OpLhb);
			end
			cpuPkg::OpHlt: wbCtrl.halt = 1'b1;
			// Unused opcodes run as no-ops
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/memWbStage.sv
`default_nettype none

module memWbStage #(
	parameter int DataAddrWidth = 8
) (
	input  logic            clk,
	input  logic            rst,
	input  cpuPkg::word_t   aluResult,
	input  cpuPkg::word_t   storeData,
	input  cpuPkg::idEx_t   idEx,
	output cpuPkg::word_t   exMemResult,
	output cpuPkg::wbCtrl_t exMemWb,
	output cpuPkg::regIdx_t exMemDst,
	output logic            exMemRead,
	output cpuPkg::word_t   memWbData,
	output cpuPkg::wbCtrl_t memWbWb,
	output cpuPkg::regIdx_t memWbDst
);

	cpuPkg::memCtrl_t         exMemMem;
	cpuPkg::word_t            exMemStore;
	cpuPkg::word_t            dataMem [2**DataAddrWidth];
	logic [DataAddrWidth-1:0] memAddr;
	cpuPkg::word_t            memData;

	// EX/MEM control
	always_ff @(posedge clk) begin
		if (rst) begin
			exMemMem <= '0;
			exMemWb  <= '0;
			exMemDst <= '0;
		end else begin
			exMemMem <= idEx.mem;
			exMemWb  <= idEx.wb;
			exMemDst <= idEx.dst;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		exMemResult <= aluResult;
		exMemStore  <= storeData;
	end

	assign exMemRead = exMemMem.memRead;

	// Word addressed, low address bits only
	assign memAddr = exMemResult[DataAddrWidth-1:0];
	assign memData = dataMem[memAddr];

	always_ff @(posedge clk) begin
		if (exMemMem.memWrite) begin
			dataMem[memAddr] <= exMemStore;
		end
	end

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			memWbWb  <= '0;
			memWbDst <= '0;
		end else begin
			memWbWb  <= exMemWb;
			memWbDst <= exMemDst;
		end
	end

	always_ff @(posedge clk) begin
		memWbData <= exMemWb.memToReg ? memData : exMemResult;
	end

	oneMemAccess: assert property (@(posedge clk) disable iff (rst)
		!(exMemMem.memRead && exMemMem.memWrite));

endmodule

`default_nettype wire

//--- verilog/pipelineIdEx.sv
`default_nettype none

module pipelineIdEx (
	input  logic             clk,
	input  logic             rst,
	input  logic             bubble,
	input  cpuPkg::exCtrl_t  exCtrl,
	input  cpuPkg::memCtrl_t memCtrl,
	input  cpuPkg::wbCtrl_t  wbCtrl,
	input  cpuPkg::word_t    data1,
	input  cpuPkg::word_t    data2,
	input  cpuPkg::regIdx_t  src1,
	input  cpuPkg::regIdx_t  src2,
	input  cpuPkg::regIdx_t  dst,
	input  cpuPkg::imm8_t    imm,
	output cpuPkg::idEx_t    idEx
);

	cpuPkg::idEx_t next;

	always_comb begin
		next.ex    = exCtrl;
		next.mem   = memCtrl;
		next.wb    = wbCtrl;
		next.data1 = data1;
		next.data2 = data2;
		next.src1  = src1;
		next.src2  = src2;
		next.dst   = dst;
		next.imm   = imm;
	end

	// Bubble zeroes every field, controls and data alike
	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			idEx <= '0;
		end else begin
			idEx <= next;
		end
	end

	bubbleIsHarmless: assert property (@(posedge clk) disable iff (rst)
		bubble |=> (!idEx.wb.regWrite && !idEx.mem.memWrite));

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`default_nettype none

module regFile (
	input  logic            clk,
	input  logic            rst,
	input  cpuPkg::regIdx_t rdAddr1,
	input  cpuPkg::regIdx_t rdAddr2,
	output cpuPkg::word_t   rdData1,
	output cpuPkg::word_t   rdData2,
	input  logic            wrEn,
	input  cpuPkg::regIdx_t wrAddr,
	input  cpuPkg::word_t   wrData
);

	cpuPkg::word_t regs [16];
	logic          wrLive;

	// Register 0 is never written
	assign wrLive = wrEn && (wrAddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-through covers the writeback cycle
	assign rdData1 = (wrLive && (wrAddr == rdAddr1)) ? wrData : regs[rdAddr1];
	assign rdData2 = (wrLive && (wrAddr == rdAddr2)) ? wrData : regs[rdAddr2];

	regZeroReadsZero: assert property (@(posedge clk) disable iff (rst)
		((rdAddr1 == '0) |-> (rdData1 == '0)) and
		((rdAddr2 == '0) |-> (rdData2 == '0)));

endmodule

`default_nettype wire

//--- vlog.f
verilog/cpuPkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/pipelineIdEx.sv
verilog/execStage.sv
verilog/memWbStage.sv
verilog/cpuCore.sv
verification/cpuCoreTb.sv
